// File: source/lamb_pkg.sv
package lamb_pkg;

   // ----------------------------------------------------------------------
   // storage geometry
   // ----------------------------------------------------------------------

   // number of stored words and their width
   localparam int lamb_depth = 24;
   localparam int lamb_data_w = 32;
   localparam int lamb_strb_w = lamb_data_w / 8;
   localparam int lamb_index_w = $clog2(lamb_depth);

   // the array is cut into blocks of at most 16 rows, the last one may be short
   localparam int lamb_max_blk_depth = 16;
   localparam int lamb_n_blks = (lamb_depth - 1) / lamb_max_blk_depth + 1;
   localparam int lamb_last_blk_depth = lamb_depth - (lamb_n_blks - 1) * lamb_max_blk_depth;

   // first row of block b
   function automatic int lamb_blk_base(input int b);
      return b * lamb_max_blk_depth;
   endfunction

   // number of rows in block b
   function automatic int lamb_blk_depth(input int b);
      return (b == lamb_n_blks - 1) ? lamb_last_blk_depth : lamb_max_blk_depth;
   endfunction

   // ----------------------------------------------------------------------
   // AXI4-Lite side
   // ----------------------------------------------------------------------

   // byte address, the two low bits select a byte and are ignored
   localparam int lamb_axi_addr_w = 8;
   localparam int lamb_byte_w = 2;
   localparam int lamb_word_w = lamb_axi_addr_w - lamb_byte_w;

   localparam logic [1:0] lamb_resp_okay = 2'b00;
   localparam logic [1:0] lamb_resp_slverr = 2'b10;

   // entry index as seen by the array
   function automatic logic [lamb_index_w-1:0] lamb_index_of(
      input logic [lamb_axi_addr_w-1:0] addr);
      return addr[lamb_byte_w +: lamb_index_w];
   endfunction

   // an address is usable only when its whole word number falls inside the array
   function automatic logic lamb_in_range(input logic [lamb_axi_addr_w-1:0] addr);
      logic [lamb_word_w-1:0] word;
      word = addr[lamb_axi_addr_w-1:lamb_byte_w];
      return (int'(word) < lamb_depth);
   endfunction

endpackage

// File: source/lamb_latch_block.sv
module lamb_latch_block
#(
   parameter int blk_depth = 16
)
(
   input  logic                             clk,
   input  logic [blk_depth-1:0]             ck,
   input  logic [lamb_pkg::lamb_data_w-1:0] wdata,
   input  logic [blk_depth-1:0]             rwl,
   output logic [lamb_pkg::lamb_data_w-1:0] y,
   output logic                             z
);
   import lamb_pkg::*;

   // each row contributes its word only while its read line is high
   logic [blk_depth-1:0][lamb_data_w-1:0] sel;

   for (genvar r = 0; r < blk_depth; r++)
   begin : g_row
      logic [lamb_data_w-1:0] q;

      // the row follows wdata while its clock line is open and holds otherwise
      always_latch
      begin
         if (ck[r])
         begin
            q <= wdata;
         end
      end

      assign sel[r] = rwl[r] ? q : '0;
   end

   // wired OR of the selected rows
   always_comb
   begin
      y = '0;
      for (int r = 0; r < blk_depth; r++)
      begin
         y = y | sel[r];
      end
   end

   // no read line of this block is active
   assign z = ~(|rwl);

   // at most one row of a block may be open at a time, checked in simulation
   always @(posedge clk)
   begin
      assert ($isunknown(ck) || $onehot0(ck))
      else $error("lamb_latch_block: more than one row open for write");
   end

endmodule

// File: source/lamb_array.sv
module lamb_array
(
   input  logic                              clk,
   input  logic                              rst_n,
   input  logic                              wen,
   input  logic [lamb_pkg::lamb_index_w-1:0] wadr,
   input  logic [lamb_pkg::lamb_data_w-1:0]  wdata,
   input  logic                              ren,
   input  logic [lamb_pkg::lamb_index_w-1:0] radr,
   output logic [lamb_pkg::lamb_data_w-1:0]  dout
);
   import lamb_pkg::*;

   // ----------------------------------------------------------------------
   // input registers
   // ----------------------------------------------------------------------

   logic [lamb_index_w-1:0] wadr_q;
   logic [lamb_index_w-1:0] radr_q;
   logic [lamb_data_w-1:0]  wdata_q;
   logic                    wr_act;

   // write address and data are taken on the write edge and kept for the open cycle
   always_ff @(posedge clk)
   begin
      if (wen)
      begin
         wadr_q <= wadr;
         wdata_q <= wdata;
      end
   end

   // read address stays until the next read, so dout is steady in between
   always_ff @(posedge clk)
   begin
      if (ren)
      begin
         radr_q <= radr;
      end
   end

   // the write row opens for exactly the cycle after wen
   always_ff @(posedge clk)
   begin
      if (!rst_n)
      begin
         wr_act <= 1'b0;
      end
      else
      begin
         wr_act <= wen;
      end
   end

   // ----------------------------------------------------------------------
   // word lines
   // ----------------------------------------------------------------------

   logic [lamb_depth-1:0] wdec;
   logic [lamb_depth-1:0] rdec;

   // one-hot decode of both registered addresses
   // the write lines are gated by the open-cycle flag
   always_comb
   begin
      for (int i = 0; i < lamb_depth; i++)
      begin
         wdec[i] = wr_act && (wadr_q == lamb_index_w'(i));
         rdec[i] = (radr_q == lamb_index_w'(i));
      end
   end

   // ----------------------------------------------------------------------
   // blocks and output
   // ----------------------------------------------------------------------

   logic [lamb_data_w-1:0] blk_y [lamb_n_blks];
   logic [lamb_n_blks-1:0] blk_z;

   for (genvar b = 0; b < lamb_n_blks; b++)
   begin : g_blk
      localparam int base = lamb_blk_base(b);
      localparam int depth = lamb_blk_depth(b);

      lamb_latch_block #(
         .blk_depth (depth)
      ) u_blk (
         .clk   (clk),
         .ck    (wdec[base +: depth]),
         .wdata (wdata_q),
         .rwl   (rdec[base +: depth]),
         .y     (blk_y[b]),
         .z     (blk_z[b])
      );
   end

   // a block with no active read line adds nothing to the output
   always_comb
   begin
      dout = '0;
      for (int b = 0; b < lamb_n_blks; b++)
      begin
         if (!blk_z[b])
         begin
            dout = dout | blk_y[b];
         end
      end
   end

endmodule

// File: source/lamb_write_port.sv
module lamb_write_port
(
   input  logic                                 clk,
   input  logic                                 rst_n,
   input  logic                                 awvalid,
   output logic                                 awready,
   input  logic [lamb_pkg::lamb_axi_addr_w-1:0] awaddr,
   input  logic                                 wvalid,
   output logic                                 wready,
   input  logic [lamb_pkg::lamb_data_w-1:0]     wdata,
   input  logic [lamb_pkg::lamb_strb_w-1:0]     wstrb,
   output logic                                 bvalid,
   input  logic                                 bready,
   output logic [1:0]                           bresp,
   output logic                                 wen,
   output logic [lamb_pkg::lamb_index_w-1:0]    wadr,
   output logic [lamb_pkg::lamb_data_w-1:0]     mem_wdata
);
   import lamb_pkg::*;

   logic hs;
   logic busy;
   logic wr_ok;
   logic pend;
   logic ok_q;

   // ----------------------------------------------------------------------
   // handshake and checks
   // ----------------------------------------------------------------------

   // a write is in flight from the handshake until its B transfer
   assign busy = pend | bvalid;

   // AW and W are taken together and only when both are offered
   assign awready = awvalid & wvalid & ~busy;
   assign wready = awready;
   assign hs = awready;

   // partial strobes and addresses past the array are refused
   assign wr_ok = lamb_in_range(awaddr) && (&wstrb);

   // the array sees the write in the handshake cycle
   assign wen = hs & wr_ok;
   assign wadr = lamb_index_of(awaddr);
   assign mem_wdata = wdata;

   // ----------------------------------------------------------------------
   // B response timing
   // ----------------------------------------------------------------------

   // pend covers the cycle in which the row is open
   // bvalid follows and stays until bready
   always_ff @(posedge clk)
   begin
      if (!rst_n)
      begin
         pend <= 1'b0;
         bvalid <= 1'b0;
      end
      else
      begin
         pend <= hs;
         if (pend)
         begin
            bvalid <= 1'b1;
         end
         else if (bready)
         begin
            bvalid <= 1'b0;
         end
      end
   end

   // outcome of the last accepted write
   always_ff @(posedge clk)
   begin
      if (hs)
      begin
         ok_q <= wr_ok;
      end
   end

   assign bresp = ok_q ? lamb_resp_okay : lamb_resp_slverr;

endmodule

// File: source/lamb_read_port.sv
module lamb_read_port
(
   input  logic                                 clk,
   input  logic                                 rst_n,
   input  logic                                 arvalid,
   output logic                                 arready,
   input  logic [lamb_pkg::lamb_axi_addr_w-1:0] araddr,
   output logic                                 rvalid,
   input  logic                                 rready,
   output logic [lamb_pkg::lamb_data_w-1:0]     rdata,
   output logic [1:0]                           rresp,
   output logic                                 ren,
   output logic [lamb_pkg::lamb_index_w-1:0]    radr,
   input  logic [lamb_pkg::lamb_data_w-1:0]     mem_rdata
);
   import lamb_pkg::*;

   logic                   hs;
   logic                   rd_ok;
   logic                   cap_due;
   logic                   ok_q;
   logic [lamb_data_w-1:0] fresh_data;
   logic [lamb_data_w-1:0] rdata_q;

   // ----------------------------------------------------------------------
   // AR channel and read issue
   // ----------------------------------------------------------------------

   // a new read is taken only once the previous R transfer is done
   assign arready = arvalid & ~rvalid;
   assign hs = arready;

   assign rd_ok = lamb_in_range(araddr);

   // out-of-range reads never touch the array
   assign ren = hs & rd_ok;
   assign radr = lamb_index_of(araddr);

   always_ff @(posedge clk)
   begin
      if (!rst_n)
      begin
         cap_due <= 1'b0;
         rvalid <= 1'b0;
      end
      else
      begin
         // dout is valid in the single cycle after the handshake
         cap_due <= hs;
         if (hs)
         begin
            rvalid <= 1'b1;
         end
         else if (rready)
         begin
            rvalid <= 1'b0;
         end
      end
   end

   always_ff @(posedge clk)
   begin
      if (hs)
      begin
         ok_q <= rd_ok;
      end
   end

   // ----------------------------------------------------------------------
   // R channel
   // ----------------------------------------------------------------------

   // an out-of-range read returns zero data
   assign fresh_data = ok_q ? mem_rdata : '0;

   // the word is taken at the end of the array's output cycle
   always_ff @(posedge clk)
   begin
      if (cap_due)
      begin
         rdata_q <= fresh_data;
      end
   end

   // in the first R cycle the array output is passed on, later the held copy
   assign rdata = cap_due ? fresh_data : rdata_q;
   assign rresp = ok_q ? lamb_resp_okay : lamb_resp_slverr;

endmodule

// File: source/lamb_top.sv
module lamb_top
(
   input  logic                                 clk,
   input  logic                                 rst_n,
   // write address and data
   input  logic                                 awvalid,
   output logic                                 awready,
   input  logic [lamb_pkg::lamb_axi_addr_w-1:0] awaddr,
   input  logic [2:0]                           awprot,
   input  logic                                 wvalid,
   output logic                                 wready,
   input  logic [lamb_pkg::lamb_data_w-1:0]     wdata,
   input  logic [lamb_pkg::lamb_strb_w-1:0]     wstrb,
   // write response
   output logic                                 bvalid,
   input  logic                                 bready,
   output logic [1:0]                           bresp,
   // read address
   input  logic                                 arvalid,
   output logic                                 arready,
   input  logic [lamb_pkg::lamb_axi_addr_w-1:0] araddr,
   input  logic [2:0]                           arprot,
   // read data
   output logic                                 rvalid,
   input  logic                                 rready,
   output logic [lamb_pkg::lamb_data_w-1:0]     rdata,
   output logic [1:0]                           rresp
);
   import lamb_pkg::*;

   // awprot and arprot carry no meaning for this memory and go nowhere

   // ----------------------------------------------------------------------
   // array side wires
   // ----------------------------------------------------------------------

   logic                    wen;
   logic [lamb_index_w-1:0] wadr;
   logic [lamb_data_w-1:0]  mem_wdata;
   logic                    ren;
   logic [lamb_index_w-1:0] radr;
   logic [lamb_data_w-1:0]  mem_rdata;

   lamb_write_port u_write_port (
      .clk       (clk),
      .rst_n     (rst_n),
      .awvalid   (awvalid),
      .awready   (awready),
      .awaddr    (awaddr),
      .wvalid    (wvalid),
      .wready    (wready),
      .wdata     (wdata),
      .wstrb     (wstrb),
      .bvalid    (bvalid),
      .bready    (bready),
      .bresp     (bresp),
      .wen       (wen),
      .wadr      (wadr),
      .mem_wdata (mem_wdata)
   );

   lamb_array u_array (
      .clk   (clk),
      .rst_n (rst_n),
      .wen   (wen),
      .wadr  (wadr),
      .wdata (mem_wdata),
      .ren   (ren),
      .radr  (radr),
      .dout  (mem_rdata)
   );

   lamb_read_port u_read_port (
      .clk       (clk),
      .rst_n     (rst_n),
      .arvalid   (arvalid),
      .arready   (arready),
      .araddr    (araddr),
      .rvalid    (rvalid),
      .rready    (rready),
      .rdata     (rdata),
      .rresp     (rresp),
      .ren       (ren),
      .radr      (radr),
      .mem_rdata (mem_rdata)
   );

endmodule

// File: tb/lamb_assertions.sv
module lamb_assertions
(
   input logic                                 clk,
   input logic                                 rst_n,
   input logic                                 awvalid,
   input logic                                 awready,
   input logic [lamb_pkg::lamb_axi_addr_w-1:0] awaddr,
   input logic                                 wvalid,
   input logic                                 wready,
   input logic [lamb_pkg::lamb_data_w-1:0]     wdata,
   input logic [lamb_pkg::lamb_strb_w-1:0]     wstrb,
   input logic                                 bvalid,
   input logic                                 bready,
   input logic [1:0]                           bresp,
   input logic                                 arvalid,
   input logic                                 arready,
   input logic [lamb_pkg::lamb_axi_addr_w-1:0] araddr,
   input logic                                 rvalid,
   input logic                                 rready,
   input logic [lamb_pkg::lamb_data_w-1:0]     rdata,
   input logic [1:0]                           rresp
);
   timeunit 1ns;
   timeprecision 1ns;

   // number of assertion failures so far
   int fail_count = 0;

   // ----------------------------------------------------------------------
   // valid and payload hold until the transfer
   // ----------------------------------------------------------------------

   aw_hold: assert property (@(posedge clk) disable iff (!rst_n)
      awvalid && !awready |=> awvalid && $stable(awaddr))
   else
   begin
      fail_count++;
      $error("awvalid or awaddr changed before the transfer");
   end

   w_hold: assert property (@(posedge clk) disable iff (!rst_n)
      wvalid && !wready |=> wvalid && $stable(wdata) && $stable(wstrb))
   else
   begin
      fail_count++;
      $error("wvalid, wdata or wstrb changed before the transfer");
   end

   ar_hold: assert property (@(posedge clk) disable iff (!rst_n)
      arvalid && !arready |=> arvalid && $stable(araddr))
   else
   begin
      fail_count++;
      $error("arvalid or araddr changed before the transfer");
   end

   // a stalled response must not move
   b_hold: assert property (@(posedge clk) disable iff (!rst_n)
      bvalid && !bready |=> bvalid && $stable(bresp))
   else
   begin
      fail_count++;
      $error("B response changed while bready was low");
   end

   r_hold: assert property (@(posedge clk) disable iff (!rst_n)
      rvalid && !rready |=> rvalid && $stable(rdata) && $stable(rresp))
   else
   begin
      fail_count++;
      $error("R response changed while rready was low");
   end

   // ----------------------------------------------------------------------
   // response timing
   // ----------------------------------------------------------------------

   // the row is open in the first cycle, the response comes in the second
   b_delay: assert property (@(posedge clk) disable iff (!rst_n)
      awvalid && awready |=> !bvalid ##1 bvalid)
   else
   begin
      fail_count++;
      $error("bvalid did not follow the write handshake by two cycles");
   end

   r_delay: assert property (@(posedge clk) disable iff (!rst_n)
      arvalid && arready |=> rvalid)
   else
   begin
      fail_count++;
      $error("rvalid did not follow the read handshake by one cycle");
   end

   // nothing is offered while reset is held and the valids are low
   reset_quiet: assert property (@(posedge clk)
      !rst_n |=> !bvalid && !rvalid && !awready && !wready && !arready)
   else
   begin
      fail_count++;
      $error("an output was active during reset");
   end

endmodule

bind lamb_top lamb_assertions asrt_i (
   .clk     (clk),
   .rst_n   (rst_n),
   .awvalid (awvalid),
   .awready (awready),
   .awaddr  (awaddr),
   .wvalid  (wvalid),
   .wready  (wready),
   .wdata   (wdata),
   .wstrb   (wstrb),
   .bvalid  (bvalid),
   .bready  (bready),
   .bresp   (bresp),
   .arvalid (arvalid),
   .arready (arready),
   .araddr  (araddr),
   .rvalid  (rvalid),
   .rready  (rready),
   .rdata   (rdata),
   .rresp   (rresp)
);

// File: tb/lamb_checker.sv
module lamb_checker
(
   input  logic                                 clk,
   input  logic                                 rst_n,
   input  logic                                 awvalid,
   input  logic                                 awready,
   input  logic [lamb_pkg::lamb_axi_addr_w-1:0] awaddr,
   input  logic                                 wvalid,
   input  logic                                 wready,
   input  logic [lamb_pkg::lamb_data_w-1:0]     wdata,
   input  logic [lamb_pkg::lamb_strb_w-1:0]     wstrb,
   input  logic                                 bvalid,
   input  logic                                 bready,
   input  logic [1:0]                           bresp,
   input  logic                                 arvalid,
   input  logic                                 arready,
   input  logic [lamb_pkg::lamb_axi_addr_w-1:0] araddr,
   input  logic                                 rvalid,
   input  logic                                 rready,
   input  logic [lamb_pkg::lamb_data_w-1:0]     rdata,
   input  logic [1:0]                           rresp,
   output int                                   err_count,
   output int                                   check_count
);
   timeunit 1ns;
   timeprecision 1ns;
   import lamb_pkg::*;

   // model memory and a flag per entry that says it holds a known word
   logic [lamb_data_w-1:0]  mem [lamb_depth];
   logic                    written [lamb_depth];

   // write that has been accepted but whose B transfer is still due
   logic                    wr_pend;
   logic                    wr_ok;
   logic [lamb_index_w-1:0] wr_idx;
   logic [lamb_data_w-1:0]  wr_data;

   // read that has been accepted, with the value or values it may return
   logic                    rd_pend;
   logic                    rd_ok;
   logic                    rd_either;
   logic [lamb_index_w-1:0] rd_idx;
   logic [lamb_data_w-1:0]  rd_old;
   logic [lamb_data_w-1:0]  rd_new;

   initial
   begin
      err_count = 0;
      check_count = 0;
      for (int i = 0; i < lamb_depth; i++)
      begin
         written[i] = 1'b0;
      end
   end

   // ----------------------------------------------------------------------
   // per-edge model update, in the order the hardware resolves it
   // ----------------------------------------------------------------------

   always @(posedge clk)
   begin
      if (!rst_n)
      begin
         wr_pend = 1'b0;
         rd_pend = 1'b0;
      end
      else
      begin
         // a completed write is visible to a read taken on the same edge
         if (bvalid && bready)
         begin
            check_count++;
            if (!wr_pend)
            begin
               err_count++;
               $display("%0t: a write response came without an accepted write", $time);
            end
            else
            begin
               if (bresp !== (wr_ok ? lamb_resp_okay : lamb_resp_slverr))
               begin
                  err_count++;
                  $display("mismatch at %0t: bresp %b for entry %0d, expected ok=%0b",
                           $time, bresp, wr_idx, wr_ok);
               end
               if (wr_ok && bresp === lamb_resp_okay)
               begin
                  mem[wr_idx] = wr_data;
                  written[wr_idx] = 1'b1;
               end
               wr_pend = 1'b0;
            end
         end

         // only full-strobe writes inside the array are expected to land
         if (awvalid && awready)
         begin
            if (!(wvalid && wready))
            begin
               err_count++;
               $display("%0t: the write address was taken without its data", $time);
            end
            wr_pend = 1'b1;
            wr_idx = awaddr[2 +: lamb_index_w];
            wr_data = wdata;
            wr_ok = (int'(awaddr[7:2]) < lamb_depth) && (wstrb == 4'hf);
         end

         if (rvalid && rready)
         begin
            check_count++;
            if (!rd_pend)
            begin
               err_count++;
               $display("%0t: read data came without an accepted read", $time);
            end
            else if (rresp !== (rd_ok ? lamb_resp_okay : lamb_resp_slverr))
            begin
               err_count++;
               $display("mismatch at %0t: rresp %b for entry %0d, expected ok=%0b",
                        $time, rresp, rd_idx, rd_ok);
            end
            else if (rdata !== rd_old && !(rd_either && rdata === rd_new))
            begin
               err_count++;
               $display("mismatch at %0t: entry %0d read %h, expected %h", $time,
                        rd_idx, rdata, rd_old);
            end
            rd_pend = 1'b0;
         end

         // a write still in flight to the same entry may or may not be seen
         if (arvalid && arready)
         begin
            rd_pend = 1'b1;
            rd_idx = araddr[2 +: lamb_index_w];
            rd_ok = int'(araddr[7:2]) < lamb_depth;
            rd_old = '0;
            rd_either = 1'b0;
            if (rd_ok)
            begin
               rd_either = wr_pend && wr_ok && (wr_idx == rd_idx);
               rd_new = wr_data;
               if (!written[rd_idx])
               begin
                  err_count++;
                  $display("%0t: stimulus read entry %0d before writing it", $time, rd_idx);
               end
               rd_old = mem[rd_idx];
            end
         end
      end
   end

endmodule

// File: tb/lamb_tb.sv
module lamb_tb;
   timeunit 1ns;
   timeprecision 1ns;
   import lamb_pkg::*;

   localparam int n_rand = 100;
   // every transaction of every test, counted as if run one after another
   localparam int n_txn = 48 + 20 + 16 + 4 * n_rand + 21;
   localparam int cycle_limit = 20 * n_txn + 8;

   logic                       clk;
   logic                       rst_n;
   logic                       awvalid;
   logic                       awready;
   logic [lamb_axi_addr_w-1:0] awaddr;
   logic [2:0]                 awprot;
   logic                       wvalid;
   logic                       wready;
   logic [lamb_data_w-1:0]     wdata;
   logic [lamb_strb_w-1:0]     wstrb;
   logic                       bvalid;
   logic                       bready;
   logic [1:0]                 bresp;
   logic                       arvalid;
   logic                       arready;
   logic [lamb_axi_addr_w-1:0] araddr;
   logic [2:0]                 arprot;
   logic                       rvalid;
   logic                       rready;
   logic [lamb_data_w-1:0]     rdata;
   logic [1:0]                 rresp;

   int                         err_count;
   int                         check_count;
   int                         err_mark;
   int                         test_no;
   int                         cycles;
   // random gaps and ready stalls are used only when this is set
   logic                       stall_en;

   lamb_top dut_i (
      .clk (clk), .rst_n (rst_n),
      .awvalid (awvalid), .awready (awready), .awaddr (awaddr), .awprot (awprot),
      .wvalid (wvalid), .wready (wready), .wdata (wdata), .wstrb (wstrb),
      .bvalid (bvalid), .bready (bready), .bresp (bresp),
      .arvalid (arvalid), .arready (arready), .araddr (araddr), .arprot (arprot),
      .rvalid (rvalid), .rready (rready), .rdata (rdata), .rresp (rresp)
   );

   lamb_checker chk_i (
      .clk (clk), .rst_n (rst_n),
      .awvalid (awvalid), .awready (awready), .awaddr (awaddr),
      .wvalid (wvalid), .wready (wready), .wdata (wdata), .wstrb (wstrb),
      .bvalid (bvalid), .bready (bready), .bresp (bresp),
      .arvalid (arvalid), .arready (arready), .araddr (araddr),
      .rvalid (rvalid), .rready (rready), .rdata (rdata), .rresp (rresp),
      .err_count (err_count), .check_count (check_count)
   );

   initial
   begin
      clk = 1'b0;
      forever
      begin
         #20 clk = ~clk;
      end
   end

   // hang guard, sized from the number of transactions
   always @(posedge clk)
   begin
      cycles++;
      if (cycles >= cycle_limit)
      begin
         $display("timeout: the run hung and was stopped after %0d cycles", cycles);
         $display("TESTS FAILED");
         $finish;
      end
   end

   // ----------------------------------------------------------------------
   // bus tasks, each entered and left on a falling edge
   // ----------------------------------------------------------------------

   function automatic logic [lamb_axi_addr_w-1:0] word_addr(input int word);
      logic [5:0] w;
      w = 6'(word);
      return {w, 2'($urandom % 4)};
   endfunction

   function automatic logic ready_pick();
      return stall_en ? 1'($urandom % 2) : 1'b1;
   endfunction

   task automatic write_txn(input logic [lamb_axi_addr_w-1:0] addr,
                            input logic [lamb_data_w-1:0] data,
                            input logic [lamb_strb_w-1:0] strb);
      int gap;
      gap = stall_en ? int'($urandom % 3) : 0;
      repeat (gap) @(negedge clk);
      awvalid = 1'b1;
      wvalid = 1'b1;
      awaddr = addr;
      wdata = data;
      wstrb = strb;
      awprot = 3'($urandom % 8);
      // ready is settled a moment after the falling edge
      #1;
      while (!awready)
      begin
         @(negedge clk);
         #1;
      end
      @(negedge clk);
      awvalid = 1'b0;
      wvalid = 1'b0;
      bready = ready_pick();
      #1;
      while (!(bvalid && bready))
      begin
         @(negedge clk);
         bready = ready_pick();
         #1;
      end
      @(negedge clk);
      bready = 1'b0;
   endtask

   task automatic read_txn(input logic [lamb_axi_addr_w-1:0] addr);
      int gap;
      gap = stall_en ? int'($urandom % 3) : 0;
      repeat (gap) @(negedge clk);
      arvalid = 1'b1;
      araddr = addr;
      arprot = 3'($urandom % 8);
      #1;
      while (!arready)
      begin
         @(negedge clk);
         #1;
      end
      @(negedge clk);
      arvalid = 1'b0;
      rready = ready_pick();
      #1;
      while (!(rvalid && rready))
      begin
         @(negedge clk);
         rready = ready_pick();
         #1;
      end
      @(negedge clk);
      rready = 1'b0;
   endtask

   // mostly in-range words, now and then anything the address can hold
   function automatic logic [lamb_axi_addr_w-1:0] rand_addr();
      return ($urandom % 4 == 0) ? word_addr(int'($urandom % 64))
                                 : word_addr(int'($urandom % lamb_depth));
   endfunction

   function automatic logic [lamb_strb_w-1:0] rand_strb();
      return ($urandom % 4 == 0) ? 4'($urandom % 16) : 4'hf;
   endfunction

   // failures seen by the checker and by the bound assertions together
   function automatic int total_errors();
      return err_count + dut_i.asrt_i.fail_count;
   endfunction

   task automatic report_test(input string name);
      int errs;
      errs = total_errors();
      test_no++;
      $display("test %0d %s: %s, %0d errors", test_no, name,
               (errs == err_mark) ? "passed" : "failed", errs - err_mark);
      err_mark = errs;
   endtask

   // ----------------------------------------------------------------------
   // test sequence
   // ----------------------------------------------------------------------

   initial
   begin
      int idx;
      void'($urandom(32'hd807));
      cycles = 0;
      err_mark = 0;
      test_no = 0;
      stall_en = 1'b1;
      rst_n = 1'b0;
      awvalid = 1'b0;
      awaddr = '0;
      awprot = '0;
      wvalid = 1'b0;
      wdata = '0;
      wstrb = '0;
      bready = 1'b0;
      arvalid = 1'b0;
      araddr = '0;
      arprot = '0;
      rready = 1'b0;
      repeat (8) @(posedge clk);
      @(negedge clk);
      rst_n = 1'b1;

      // every entry, so both blocks are covered
      for (int i = 0; i < lamb_depth; i++)
      begin
         write_txn(word_addr(i), $urandom, 4'hf);
      end
      for (int i = 0; i < lamb_depth; i++)
      begin
         read_txn(word_addr(i));
      end
      report_test("full-strobe writes and read back");

      // words 32 and 40 alias entries 0 and 8 in the low index bits
      write_txn(word_addr(32), $urandom, 4'hf);
      write_txn(word_addr(40), $urandom, 4'hf);
      for (int k = 0; k < 6; k++)
      begin
         write_txn(word_addr(lamb_depth + int'($urandom % 40)), $urandom, 4'hf);
      end
      for (int k = 0; k < 8; k++)
      begin
         read_txn(word_addr(lamb_depth + int'($urandom % 40)));
      end
      read_txn(word_addr(0));
      read_txn(word_addr(8));
      read_txn(word_addr(16));
      read_txn(word_addr(lamb_depth - 1));
      report_test("out-of-range accesses");

      for (int k = 0; k < 8; k++)
      begin
         idx = int'($urandom % lamb_depth);
         write_txn(word_addr(idx), $urandom, 4'($urandom % 15));
         read_txn(word_addr(idx));
      end
      report_test("partial strobes refused");

      // independent write and read streams, first stalled, then flat out
      for (int pass = 0; pass < 2; pass++)
      begin
         stall_en = (pass == 0);
         fork
            for (int k = 0; k < n_rand; k++)
            begin
               write_txn(rand_addr(), $urandom, rand_strb());
            end
            for (int k = 0; k < n_rand; k++)
            begin
               read_txn(rand_addr());
            end
         join
      end
      report_test("stalls and back-to-back traffic");

      stall_en = 1'b1;
      for (int round = 0; round < 3; round++)
      begin
         idx = int'($urandom % lamb_depth);
         repeat (6) write_txn(word_addr(idx), $urandom, 4'hf);
         read_txn(word_addr(idx));
      end
      report_test("repeated overwrite");

      $display("summary: %0d tests, %0d checks, %0d errors", test_no, check_count,
               total_errors());
      if (total_errors() == 0 && check_count > 0)
      begin
         $display("TESTS PASSED");
      end
      else
      begin
         $display("TESTS FAILED");
      end
      $finish;
   end

endmodule

// File: all.f
source/lamb_pkg.sv
source/lamb_latch_block.sv
source/lamb_array.sv
source/lamb_write_port.sv
source/lamb_read_port.sv
source/lamb_top.sv
tb/lamb_assertions.sv
tb/lamb_checker.sv
tb/lamb_tb.sv

// File: run_sim.sh
#!/bin/sh
# build and run the testbench with Verilator, then judge the log

cd "$(dirname "$0")" || exit 1

fail_msg="TESTS FAILED"

verilator --binary --timing --assert -f all.f --top-module lamb_tb \
   -Mdir obj_dir -o lamb_sim > build.log 2>&1
if [ $? -ne 0 ]; then
   echo "build failed, see build.log"
   exit 1
fi

./obj_dir/lamb_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
   echo "simulation exited with status $status"
   exit 1
fi

if grep -q "$fail_msg" sim.log; then
   echo "simulation reported failure"
   exit 1
fi

if ! grep -q "summary:" sim.log; then
   echo "simulation ended without a summary"
   exit 1
fi

exit 0
